//--- hdl/div_defs.svh
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// integer register width of the core
`define DIV_XLEN 64

// byte address width of the register window
// four 64-bit registers, 8 bytes apart
`define DIV_ADR_W 6

// last divider counter value
// load step at 0, then 65 shift steps
`define DIV_ITER_LAST 66

// register byte offsets
`define DIV_REG_OPA    6'h00
`define DIV_REG_OPB    6'h08
`define DIV_REG_CTRL   6'h10
`define DIV_REG_RESULT 6'h18

`endif

//--- hdl/div_op_pkg.sv
`include "div_defs.svh"

package div_op_pkg;

    // M-extension divide operations
    // bit 0 unsigned, bit 1 remainder, bit 2 32-bit word form
    typedef enum logic [2:0] {
        DIV   = 3'd0,
        DIVU  = 3'd1,
        REM   = 3'd2,
        REMU  = 3'd3,
        DIVW  = 3'd4,
        DIVUW = 3'd5,
        REMW  = 3'd6,
        REMUW = 3'd7
    } div_op_e;

    // operands handed to the divider core
    typedef struct packed {
        logic                 is_signed;
        logic                 is_word;
        logic [`DIV_XLEN-1:0] dividend;
        logic [`DIV_XLEN-1:0] divisor;
    } div_req_t;

    // core result word
    // written as one raw word, read back as remainder and quotient
    typedef union packed {
        logic [2*`DIV_XLEN-1:0] raw;
        struct packed {
            logic [`DIV_XLEN-1:0] rem;
            logic [`DIV_XLEN-1:0] quot;
        } parts;
    } div_result_u;

endpackage

//--- hdl/div_bus_pkg.sv
`include "div_defs.svh"

package div_bus_pkg;

    // Wishbone classic master to slave
    // cyc and stb held high until ack is seen
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        // byte address inside the register window
        logic [`DIV_ADR_W-1:0] adr;
        // whole-word write data, no byte select
        logic [`DIV_XLEN-1:0]  dat_w;
    } wb_req_t;

    // Wishbone classic slave to master
    typedef struct packed {
        // single-cycle acknowledge
        logic                 ack;
        // read data, valid with ack
        logic [`DIV_XLEN-1:0] dat_r;
    } wb_rsp_t;

endpackage

//--- hdl/div_core.sv
`include "div_defs.svh"

module div_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid,
    input  div_op_pkg::div_req_t    req,
    output logic                    ready,
    output div_op_pkg::div_result_u result
);

    // one extra bit so unsigned 64-bit operands stay positive
    localparam int W = `DIV_XLEN + 1;
    localparam int HALF = `DIV_XLEN / 2;
    localparam int CNT_W = $clog2(`DIV_ITER_LAST + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DIV_ITER_LAST);

    // sign or zero extension of one operand to the 65-bit datapath
    function automatic logic [W-1:0] extend(
        input logic [`DIV_XLEN-1:0] value,
        input logic                 sgn,
        input logic                 word
    );
        logic fill;
        fill = sgn & (word ? value[HALF-1] : value[`DIV_XLEN-1]);
        if (word) begin
            return {{(W-HALF){fill}}, value[HALF-1:0]};
        end
        return {fill, value};
    endfunction

    // step counter, 0 is the load step
    logic [CNT_W-1:0] cnt;
    // dividend sign and extended divisor, captured on the load step
    logic             opa_sign;
    logic [W-1:0]     opb_q;
    // partial remainder and shared dividend / quotient shifter
    logic [W-1:0]     rem_q;
    logic [W-1:0]     quot_q;

    logic [W-1:0]     ext_a;
    logic [W-1:0]     ext_b;
    logic             load;
    logic             sub;
    logic [W-1:0]     shifted;
    logic [W-1:0]     partial;

    logic [W-1:0]     min_neg;
    logic             div_zero;
    logic             overflow;
    logic             special;
    logic [2*`DIV_XLEN-1:0] special_word;

    logic             rem_nz;
    logic             fix;
    logic [W-1:0]     rem_corr;
    logic [W-1:0]     rem_fix;
    logic [W-1:0]     quot_raw;
    logic [W-1:0]     quot_fix;

    assign ext_a = extend(req.dividend, req.is_signed, req.is_word);
    assign ext_b = extend(req.divisor, req.is_signed, req.is_word);
    assign load  = (cnt == '0);

    // subtract when partial remainder and divisor agree in sign
    // same decision doubles as the quotient digit of this step
    assign sub     = (rem_q[W-1] == opb_q[W-1]);
    // next dividend bit enters from the top of the shifter
    assign shifted = {rem_q[W-2:0], quot_q[W-1]};
    // wraps on the shift, true result always fits 65 bits
    assign partial = sub ? shifted - opb_q : shifted + opb_q;

    // most negative value, as seen after extension
    assign min_neg = req.is_word ? {{(W-HALF+1){1'b1}}, {(HALF-1){1'b0}}}
                                 : {2'b11, {(W-2){1'b0}}};

    // special cases only looked at in the request cycle
    assign div_zero = (ext_b == '0);
    // all ones at 65 bits only happens for signed -1
    assign overflow = (ext_a == min_neg) & (&ext_b);
    assign special  = load & (div_zero | overflow);

    // x/0 gives quot all ones, rem x
    // min/-1 gives quot min, rem 0
    assign special_word = div_zero ? {ext_a[`DIV_XLEN-1:0], {`DIV_XLEN{1'b1}}}
                                   : {{`DIV_XLEN{1'b0}}, ext_a[`DIV_XLEN-1:0]};

    // digits are +1/-1, so quotient is 2p - 2^65 + 1
    assign quot_raw = {quot_q[W-2:0], 1'b1};

    // one more step toward zero for the remainder
    assign rem_corr = sub ? rem_q - opb_q : rem_q + opb_q;
    assign rem_nz   = |rem_q;
    // wrong sign, or remainder equal to -|divisor| on an exact multiple
    assign fix = rem_nz & ((rem_q[W-1] ^ opa_sign) | (rem_corr == '0));

    assign rem_fix  = fix ? rem_corr : rem_q;
    always_comb begin
        quot_fix = quot_raw;
        if (fix) begin
            quot_fix = sub ? quot_raw + W'(1) : quot_raw - W'(1);
        end
    end

    assign ready = valid & (special | (cnt == CNT_LAST));

    assign result.raw = special ? special_word
                                : {rem_fix[`DIV_XLEN-1:0], quot_fix[`DIV_XLEN-1:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            rem_q  <= '0;
            quot_q <= '0;
        end else if (valid) begin
            if (ready) begin
                // done, back to idle for the next request
                cnt    <= '0;
                rem_q  <= '0;
                quot_q <= '0;
            end else if (load) begin
                cnt    <= cnt + 1'b1;
                // high half starts as the sign of the dividend
                rem_q  <= {W{ext_a[W-1]}};
                quot_q <= ext_a;
            end else begin
                cnt    <= cnt + 1'b1;
                rem_q  <= partial;
                quot_q <= {quot_q[W-2:0], sub};
            end
        end
    end

    // operands frozen for the iterations
    always_ff @(posedge clk) begin
        if (valid && load) begin
            opa_sign <= ext_a[W-1];
            opb_q    <= ext_b;
        end
    end

endmodule

//--- hdl/div_wb_regs.sv
`include "div_defs.svh"

module div_wb_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  div_bus_pkg::wb_req_t    wb_req,
    output div_bus_pkg::wb_rsp_t    wb_rsp,
    output logic                    div_valid,
    output div_op_pkg::div_req_t    div_req,
    input  logic                    div_ready,
    input  div_op_pkg::div_result_u div_result
);

    localparam int HALF = `DIV_XLEN / 2;

    // programmer visible registers
    logic [`DIV_XLEN-1:0] opa;
    logic [`DIV_XLEN-1:0] opb;
    div_op_pkg::div_op_e  op;
    logic [`DIV_XLEN-1:0] result_q;

    // request to the core, frozen at the CTRL write
    div_op_pkg::div_req_t req_q;
    // divide in flight
    logic                 busy;

    // bus handshake state
    logic                 ack_q;
    logic                 served;
    logic [`DIV_XLEN-1:0] dat_r_q;

    logic                 cycle;
    logic                 hit_opa;
    logic                 hit_opb;
    logic                 hit_ctrl;
    logic                 hit_res;
    logic                 stall;
    logic                 take;
    logic                 done;
    logic [`DIV_XLEN-1:0] rd_data;
    logic [`DIV_XLEN-1:0] sel_word;
    logic [`DIV_XLEN-1:0] fmt_word;

    assign cycle    = wb_req.cyc & wb_req.stb;
    assign hit_opa  = (wb_req.adr == `DIV_REG_OPA);
    assign hit_opb  = (wb_req.adr == `DIV_REG_OPB);
    assign hit_ctrl = (wb_req.adr == `DIV_REG_CTRL);
    assign hit_res  = (wb_req.adr == `DIV_REG_RESULT);

    // new start or result read has to wait for the running divide
    assign stall = busy & ((wb_req.we & hit_ctrl) | (~wb_req.we & hit_res));
    // one ack per strobe, then wait for stb to fall
    assign take  = cycle & ~served & ~stall;
    assign done  = busy & div_ready;

    // read mux, unmapped offsets read zero
    always_comb begin
        rd_data = '0;
        if (hit_opa) begin
            rd_data = opa;
        end else if (hit_opb) begin
            rd_data = opb;
        end else if (hit_ctrl) begin
            rd_data = {{(`DIV_XLEN-3){1'b0}}, op};
        end else if (hit_res) begin
            rd_data = result_q;
        end
    end

    // op bit 1 picks remainder, bit 2 sign-extends the low word
    assign sel_word = op[1] ? div_result.parts.rem : div_result.parts.quot;
    assign fmt_word = op[2] ? {{HALF{sel_word[HALF-1]}}, sel_word[HALF-1:0]} : sel_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q    <= 1'b0;
            served   <= 1'b0;
            busy     <= 1'b0;
            opa      <= '0;
            opb      <= '0;
            op       <= div_op_pkg::DIV;
            result_q <= '0;
        end else begin
            ack_q <= take;
            if (take) begin
                served <= 1'b1;
            end else if (!cycle) begin
                served <= 1'b0;
            end
            // core handshake, ready drops valid on this edge
            if (done) begin
                busy     <= 1'b0;
                result_q <= fmt_word;
            end
            if (take && wb_req.we) begin
                if (hit_opa) begin
                    opa <= wb_req.dat_w;
                end
                if (hit_opb) begin
                    opb <= wb_req.dat_w;
                end
                // never taken while busy, so no clash with done
                if (hit_ctrl) begin
                    op   <= div_op_pkg::div_op_e'(wb_req.dat_w[2:0]);
                    busy <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && !wb_req.we) begin
            dat_r_q <= rd_data;
        end
        // operands may change afterwards without touching the core
        if (take && wb_req.we && hit_ctrl) begin
            req_q.is_signed <= ~wb_req.dat_w[0];
            req_q.is_word   <= wb_req.dat_w[2];
            req_q.dividend  <= opa;
            req_q.divisor   <= opb;
        end
    end

    assign div_valid    = busy;
    assign div_req      = req_q;
    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;

endmodule

//--- hdl/div_unit_top.sv
module div_unit_top (
    input  logic                 clk,
    input  logic                 rst,
    input  div_bus_pkg::wb_req_t wb_req,
    output div_bus_pkg::wb_rsp_t wb_rsp
);

    // register block to core handshake
    logic                    div_valid;
    logic                    div_ready;
    div_op_pkg::div_req_t    div_req;
    // raw word from the core, split again in the register block
    div_op_pkg::div_result_u div_result;

    // bus side, operands, start and result formatting
    div_wb_regs div_wb_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .div_valid  (div_valid),
        .div_req    (div_req),
        .div_ready  (div_ready),
        .div_result (div_result)
    );

    // iterative divider
    div_core div_core_inst (
        .clk    (clk),
        .rst    (rst),
        .valid  (div_valid),
        .req    (div_req),
        .ready  (div_ready),
        .result (div_result)
    );

endmodule

//--- sim/div_unit_tb.sv
`include "div_defs.svh"

module div_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_TESTS = 64;
    localparam int NAME_W = 8 * 24;
    // per access, covers a full divide plus one stalled behind it
    localparam int ACK_LIMIT = 200;

    logic                 clk;
    logic                 rst;
    div_bus_pkg::wb_req_t wb_req;
    div_bus_pkg::wb_rsp_t wb_rsp;

    // test table loaded from the stimulus file
    logic [NAME_W-1:0]    t_name [MAX_TESTS];
    logic [7:0]           t_kind [MAX_TESTS];
    logic [`DIV_XLEN-1:0] t_a    [MAX_TESTS];
    logic [`DIV_XLEN-1:0] t_b    [MAX_TESTS];
    logic [`DIV_XLEN-1:0] t_exp  [MAX_TESTS];

    int   n_tests = 0;
    int   pass_cnt = 0;
    int   fail_cnt = 0;
    int   cycles = 0;
    // raised once the table is known
    int   cycle_limit = 200;
    // set by a bus access that never saw ack
    logic bus_fault;

    div_unit_top div_unit_top_inst (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // global run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout waiting for DUT");
            $display("Regression failed");
            $finish;
        end
    end

    // one Wishbone classic cycle, driven on the falling edge
    task automatic wb_transfer(
        input  logic                  we,
        input  logic [`DIV_ADR_W-1:0] adr,
        input  logic [`DIV_XLEN-1:0]  wdata,
        output logic [`DIV_XLEN-1:0]  rdata
    );
        int   waited;
        logic acked;
        @(negedge clk);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = wdata;
        waited = 0;
        acked  = 1'b0;
        rdata  = '0;
        // ack sampled mid-cycle, well clear of the rising edge
        while (!acked && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdata = wb_rsp.dat_r;
            end
        end
        if (!acked) begin
            bus_fault = 1'b1;
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic bus_write(
        input logic [`DIV_ADR_W-1:0] adr,
        input logic [`DIV_XLEN-1:0]  data
    );
        logic [`DIV_XLEN-1:0] unused;
        wb_transfer(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(
        input  logic [`DIV_ADR_W-1:0] adr,
        output logic [`DIV_XLEN-1:0]  data
    );
        wb_transfer(1'b0, adr, '0, data);
    endtask

    // operands first, then the CTRL write that starts the core
    task automatic start_divide(
        input logic [`DIV_XLEN-1:0] a,
        input logic [`DIV_XLEN-1:0] b,
        input logic [2:0]           op
    );
        bus_write(`DIV_REG_OPA, a);
        bus_write(`DIV_REG_OPB, b);
        bus_write(`DIV_REG_CTRL, {{(`DIV_XLEN-3){1'b0}}, op});
    endtask

    // result register loaded with a chosen value
    // remainder of a divide by zero is the dividend itself
    task automatic preset_result(input logic [`DIV_XLEN-1:0] value);
        bus_write(`DIV_REG_OPA, value);
        bus_write(`DIV_REG_OPB, '0);
        bus_write(`DIV_REG_CTRL, {{(`DIV_XLEN-3){1'b0}}, div_op_pkg::REMU});
    endtask

    task automatic run_test(input int idx);
        logic [`DIV_XLEN-1:0] got;
        logic [7:0]           kind;
        logic                 unknown;
        kind      = t_kind[idx];
        got       = '0;
        unknown   = 1'b0;
        bus_fault = 1'b0;
        if (kind < 8'h08) begin
            // stale result never equals the expected one
            preset_result(~t_exp[idx]);
            // plain divide, result read straight after the start
            start_divide(t_a[idx], t_b[idx], kind[2:0]);
            bus_read(`DIV_REG_RESULT, got);
        end else begin
            case (kind)
                8'h08: begin
                    bus_write(`DIV_REG_OPA, t_a[idx]);
                    bus_read(`DIV_REG_OPA, got);
                end
                8'h09: begin
                    bus_write(`DIV_REG_OPB, t_a[idx]);
                    bus_read(`DIV_REG_OPB, got);
                end
                8'h0a: begin
                    bus_write(`DIV_REG_CTRL, t_a[idx]);
                    bus_read(`DIV_REG_CTRL, got);
                end
                8'h0b: begin
                    // operand a is the offset, b the ignored write data
                    bus_write(t_a[idx][`DIV_ADR_W-1:0], t_b[idx]);
                    bus_read(t_a[idx][`DIV_ADR_W-1:0], got);
                end
                8'h0c: begin
                    preset_result(~t_exp[idx]);
                    // second start lands while the first divide runs
                    start_divide(t_a[idx], t_b[idx], div_op_pkg::DIVU);
                    bus_write(`DIV_REG_CTRL, {{(`DIV_XLEN-3){1'b0}}, div_op_pkg::REMU});
                    bus_read(`DIV_REG_RESULT, got);
                end
                default: begin
                    unknown = 1'b1;
                end
            endcase
        end
        if (unknown) begin
            $display("%0s: unknown test kind in stimulus file", t_name[idx]);
            fail_cnt++;
        end else if (bus_fault) begin
            $display("%0s: no acknowledge from bus", t_name[idx]);
            fail_cnt++;
        end else if (got !== t_exp[idx]) begin
            $display("FAIL %0s expected %h actual %h", t_name[idx], t_exp[idx], got);
            fail_cnt++;
        end else begin
            $display("pass %0s", t_name[idx]);
            pass_cnt++;
        end
    endtask

    initial begin
        int                   fd;
        int                   got_len;
        string                line;
        logic [NAME_W-1:0]    name_buf;
        logic [7:0]           kind_buf;
        logic [`DIV_XLEN-1:0] a_buf;
        logic [`DIV_XLEN-1:0] b_buf;
        logic [`DIV_XLEN-1:0] exp_buf;
        rst       = 1'b1;
        wb_req    = '0;
        bus_fault = 1'b0;
        fd = $fopen("sim/div_stim.txt", "r");
        if (fd == 0) begin
            $display("stimulus file sim/div_stim.txt could not be opened");
            fail_cnt++;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                got_len = $fgets(line, fd);
                // comment lines start with a hash
                if (got_len > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%s %h %h %h %h", name_buf, kind_buf,
                                a_buf, b_buf, exp_buf) == 5) begin
                        t_name[n_tests] = name_buf;
                        t_kind[n_tests] = kind_buf;
                        t_a[n_tests]    = a_buf;
                        t_b[n_tests]    = b_buf;
                        t_exp[n_tests]  = exp_buf;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = n_tests * 100 + 200;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && n_tests > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- div_unit_top.f
+incdir+hdl
hdl/div_op_pkg.sv
hdl/div_bus_pkg.sv
hdl/div_core.sv
hdl/div_wb_regs.sv
hdl/div_unit_top.sv
sim/div_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the divide unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps --top-module div_unit_tb \
    -f div_unit_top.f -o div_unit_sim || { echo "verilator build failed"; exit 1; }
sim_out="$(./obj_dir/div_unit_sim)"
echo "$sim_out"
# pass only when the run printed the pass line
echo "$sim_out" | grep -q "Regression passed" && exit 0 || exit 1

//--- sim/div_stim.txt
# columns: name, kind (hex), operand a (hex), operand b (hex), expected result (hex)
# kind 0-7 divide op code, 8 opa, 9 opb, a ctrl, b unmapped offset a, c divu then remu
reg_opa 8 0123456789abcdef 0 0123456789abcdef
reg_opb 9 fedcba9876543210 0 fedcba9876543210
reg_ctrl a fffffffffffffffd 0 5
reg_unmapped b 20 ffffffffffffffff 0
divu_basic 1 64 7 e
remu_small 3 5 9 5
divu_top_bit 1 ffffffffffffffff 2 7fffffffffffffff
remu_top_both 3 fffffffffffffffe 8000000000000000 7ffffffffffffffe
div_pos_pos 0 64 7 e
div_neg_pos 0 ffffffffffffff9c 7 fffffffffffffff2
rem_neg_pos 2 ffffffffffffff9c 7 fffffffffffffffe
div_pos_neg 0 64 fffffffffffffff9 fffffffffffffff2
rem_pos_neg 2 64 fffffffffffffff9 2
div_neg_neg 0 ffffffffffffff9c fffffffffffffff9 e
rem_neg_neg 2 ffffffffffffff9c fffffffffffffff9 fffffffffffffffe
div_exact 0 ffffffffffffffeb 7 fffffffffffffffd
rem_exact 2 ffffffffffffffeb 7 0
div_zero 0 1234 0 ffffffffffffffff
divu_zero 1 8000000000000000 0 ffffffffffffffff
rem_zero 2 ffffffffffffff9c 0 ffffffffffffff9c
remu_zero 3 fedcba9876543210 0 fedcba9876543210
divw_zero 4 1234 ffffffff00000000 ffffffffffffffff
divuw_zero 5 1234 0 ffffffffffffffff
remw_zero 6 0000000080000005 0 ffffffff80000005
remuw_zero 7 aaaaaaaa00001234 5555555500000000 1234
div_ovf 0 8000000000000000 ffffffffffffffff 8000000000000000
rem_ovf 2 8000000000000000 ffffffffffffffff 0
divw_ovf 4 0000000080000000 00000000ffffffff ffffffff80000000
remw_ovf 6 1234567880000000 abcdef00ffffffff 0
divw_basic 4 12345678ffffff9c abcdef0000000007 fffffffffffffff2
remw_basic 6 12345678ffffff9c abcdef0000000007 fffffffffffffffe
divuw_bit31 5 00000000fffffffe ffffffff00000001 fffffffffffffffe
remuw_basic 7 ffffffff00000064 0000000100000007 2
bp_chain c 64 7 2
